//--- Makefile
SIM = obj_dir/Vautotest_tb

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

$(SIM): all.f $(wildcard src/*.sv verif/*.sv)
	verilator --binary --timing -Wno-fatal --top-module autotest_tb -f all.f

clean:
	rm -rf obj_dir

//--- all.f
src/autotest_pkg.sv
src/autotest_fsm.sv
src/block_buffer.sv
src/vector_capture.sv
src/exec_timer.sv
src/result_writer.sv
src/autotest_top.sv
verif/sd_card_model.sv
verif/autotest_tb.sv

//--- src/autotest_fsm.sv
// sequencer FSM: block read, UUT run, result write-back, with byte, block and error counters
`timescale 1ns/1ps
`default_nettype none

module autotest_fsm (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             start_i,
  input  logic                             spi_busy_i,
  input  logic                             sig_ok_i,
  input  logic                             result_bad_i,
  input  logic                             uut_end_i,
  input  logic                             uut_err_i,
  input  logic                             timed_out_i,
  output logic                             spi_rst_o,
  output logic                             spi_r_block_o,
  output logic                             spi_r_byte_o,
  output logic                             spi_w_block_o,
  output logic                             spi_w_byte_o,
  output logic [autotest_pkg::ADDR_W-1:0]  spi_block_addr_o,
  output logic                             uut_rst_o,
  output logic [autotest_pkg::BYTE_W-1:0]  byte_idx_o,
  output logic                             load_byte_o,
  output logic                             buf_we_o,
  output logic                             capture_out_o,
  output logic                             timer_clr_o,
  output logic                             timer_run_o,
  output logic                             send_byte_o,
  output logic [autotest_pkg::ERR_W-1:0]   err_count_o
);

  logic [autotest_pkg::STATE_W-1:0] state_q;
  logic [autotest_pkg::STATE_W-1:0] state_d;
  logic [autotest_pkg::BYTE_W-1:0] byte_idx_q;
  logic [autotest_pkg::ADDR_W-1:0] block_addr_q;
  logic [autotest_pkg::ERR_W-1:0] err_q;
  logic busy_seen_q;
  logic settle_q;
  logic run_err_q;
  logic run_done;
  logic last_read;
  logic write_done;

  assign run_done = uut_end_i | uut_err_i | timed_out_i;
  assign last_read = int'(byte_idx_q) == autotest_pkg::BLOCK_BYTES - 1;
  assign write_done = int'(byte_idx_q) == autotest_pkg::BLOCK_BYTES;

  assign spi_block_addr_o = block_addr_q;
  assign byte_idx_o = byte_idx_q;
  assign err_count_o = err_q;
  // UUT leaves reset only while running
  assign uut_rst_o = state_q != autotest_pkg::ST_RUN;

  always_comb
  begin
    state_d = state_q;
    spi_rst_o = 1'b0;
    spi_r_block_o = 1'b0;
    spi_r_byte_o = 1'b0;
    spi_w_block_o = 1'b0;
    spi_w_byte_o = 1'b0;
    load_byte_o = 1'b0;
    buf_we_o = 1'b0;
    capture_out_o = 1'b0;
    timer_clr_o = 1'b0;
    timer_run_o = 1'b0;
    send_byte_o = 1'b0;
    case (state_q)
      autotest_pkg::ST_WAIT_START:
        if (start_i)
          state_d = autotest_pkg::ST_SPI_RST;
      autotest_pkg::ST_SPI_RST:
      begin
        spi_rst_o = 1'b1;
        if (spi_busy_i)
          state_d = autotest_pkg::ST_WAIT_RST;
      end
      autotest_pkg::ST_WAIT_RST:
        if (!spi_busy_i)
          state_d = autotest_pkg::ST_OPEN_READ;
      autotest_pkg::ST_OPEN_READ:
      begin
        // host answers the open with one busy pulse
        spi_r_block_o = 1'b1;
        if (busy_seen_q && !spi_busy_i)
          state_d = autotest_pkg::ST_READ_BYTE;
      end
      autotest_pkg::ST_READ_BYTE:
      begin
        spi_r_block_o = 1'b1;
        spi_r_byte_o = 1'b1;
        if (spi_busy_i)
          state_d = autotest_pkg::ST_WAIT_BYTE;
      end
      autotest_pkg::ST_WAIT_BYTE:
      begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i)
        begin
          load_byte_o = 1'b1;
          buf_we_o = 1'b1;
          state_d = last_read ? autotest_pkg::ST_CHECK_SIG : autotest_pkg::ST_READ_BYTE;
        end
      end
      autotest_pkg::ST_CHECK_SIG:
      begin
        timer_clr_o = 1'b1;
        state_d = sig_ok_i ? autotest_pkg::ST_RUN : autotest_pkg::ST_WAIT_START;
      end
      autotest_pkg::ST_RUN:
      begin
        timer_run_o = 1'b1;
        if (run_done)
        begin
          capture_out_o = 1'b1;
          state_d = autotest_pkg::ST_CAPTURE;
        end
      end
      autotest_pkg::ST_CAPTURE:
        state_d = autotest_pkg::ST_OPEN_WRITE;
      autotest_pkg::ST_OPEN_WRITE:
      begin
        spi_w_block_o = 1'b1;
        if (busy_seen_q && !spi_busy_i)
        begin
          send_byte_o = 1'b1;
          state_d = autotest_pkg::ST_SEND_BYTE;
        end
      end
      autotest_pkg::ST_SEND_BYTE:
      begin
        spi_w_block_o = 1'b1;
        spi_w_byte_o = 1'b1;
        if (spi_busy_i)
          state_d = autotest_pkg::ST_WAIT_SEND;
      end
      autotest_pkg::ST_WAIT_SEND:
      begin
        // one settle cycle for the buffer read of the new index
        spi_w_block_o = 1'b1;
        if (settle_q && !spi_busy_i)
        begin
          if (write_done)
            state_d = autotest_pkg::ST_NEXT_BLOCK;
          else
          begin
            send_byte_o = 1'b1;
            state_d = autotest_pkg::ST_SEND_BYTE;
          end
        end
      end
      autotest_pkg::ST_NEXT_BLOCK:
        state_d = autotest_pkg::ST_OPEN_READ;
      default:
        state_d = autotest_pkg::ST_WAIT_START;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= autotest_pkg::ST_WAIT_START;
      byte_idx_q <= '0;
      block_addr_q <= autotest_pkg::START_BLOCK;
      err_q <= '0;
      busy_seen_q <= 1'b0;
      settle_q <= 1'b0;
      run_err_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // both flags restart on every state change
      busy_seen_q <= (state_d == state_q) & (busy_seen_q | spi_busy_i);
      settle_q <= state_d == state_q;
      case (state_q)
        autotest_pkg::ST_WAIT_START:
          if (start_i)
          begin
            block_addr_q <= autotest_pkg::START_BLOCK;
            err_q <= '0;
          end
        autotest_pkg::ST_OPEN_READ, autotest_pkg::ST_OPEN_WRITE:
          byte_idx_q <= '0;
        autotest_pkg::ST_WAIT_BYTE:
          if (!spi_busy_i)
            byte_idx_q <= byte_idx_q + 1'b1;
        autotest_pkg::ST_RUN:
          if (run_done)
            run_err_q <= uut_err_i;
        autotest_pkg::ST_CAPTURE:
          if (result_bad_i | run_err_q)
            err_q <= err_q + 1'b1;
        autotest_pkg::ST_SEND_BYTE:
          // host has sampled this byte
          if (spi_busy_i)
            byte_idx_q <= byte_idx_q + 1'b1;
        autotest_pkg::ST_NEXT_BLOCK:
          block_addr_q <= block_addr_q + 1'b1;
        default:
          ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/autotest_pkg.sv
// autotest package: SD block layout, field sizes, limits and sequencer state codes
`default_nettype none

package autotest_pkg;

  // SD block geometry
  localparam int BLOCK_BYTES = 512;
  localparam int BYTE_W = 10;
  localparam int ADDR_W = 32;
  localparam logic [ADDR_W-1:0] START_BLOCK = 32'h0000_0100;

  // bytes 0 to 3, byte 0 most significant
  localparam logic [31:0] SIGNATURE = 32'hAABB_CCDD;

  // field sizes, stored little-endian inside the block
  localparam int IN_BYTES = 4;
  localparam int IN_W = 8 * IN_BYTES;
  localparam int OUT_BYTES = 4;
  localparam int OUT_W = 8 * OUT_BYTES;
  localparam int TIME_BYTES = 8;
  localparam int TIME_W = 8 * TIME_BYTES;

  // field offsets, time field follows the result field
  localparam int IN_BASE = 4;
  localparam int EXP_BASE = IN_BASE + IN_BYTES;
  localparam int RES_BASE = EXP_BASE + OUT_BYTES;

  // short limit, keeps simulation quick
  localparam logic [TIME_W-1:0] TIMEOUT_CYCLES = 200;
  localparam int ERR_W = 16;

  // sequencer states
  localparam int STATE_W = 4;
  localparam logic [STATE_W-1:0] ST_WAIT_START = 4'd0;
  localparam logic [STATE_W-1:0] ST_SPI_RST = 4'd1;
  localparam logic [STATE_W-1:0] ST_WAIT_RST = 4'd2;
  localparam logic [STATE_W-1:0] ST_OPEN_READ = 4'd3;
  localparam logic [STATE_W-1:0] ST_READ_BYTE = 4'd4;
  localparam logic [STATE_W-1:0] ST_WAIT_BYTE = 4'd5;
  localparam logic [STATE_W-1:0] ST_CHECK_SIG = 4'd6;
  localparam logic [STATE_W-1:0] ST_RUN = 4'd7;
  localparam logic [STATE_W-1:0] ST_CAPTURE = 4'd8;
  localparam logic [STATE_W-1:0] ST_OPEN_WRITE = 4'd9;
  localparam logic [STATE_W-1:0] ST_SEND_BYTE = 4'd10;
  localparam logic [STATE_W-1:0] ST_WAIT_SEND = 4'd11;
  localparam logic [STATE_W-1:0] ST_NEXT_BLOCK = 4'd12;

endpackage

`default_nettype wire

//--- src/autotest_top.sv
// autotest top: SD-driven test sequencer around a unit under test
`timescale 1ns/1ps
`default_nettype none

module autotest_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             start_i,
  input  logic                             spi_busy_i,
  input  logic [7:0]                       spi_data_out_i,
  output logic [autotest_pkg::ADDR_W-1:0]  spi_block_addr_o,
  output logic                             spi_r_block_o,
  output logic                             spi_r_byte_o,
  output logic                             spi_rst_o,
  output logic                             spi_w_block_o,
  output logic                             spi_w_byte_o,
  output logic [7:0]                       spi_data_in_o,
  output logic                             uut_rst_o,
  output logic [autotest_pkg::IN_W-1:0]    uut_din_o,
  input  logic                             uut_end_i,
  input  logic                             uut_err_i,
  input  logic [autotest_pkg::OUT_W-1:0]   uut_dout_i,
  output logic [autotest_pkg::ERR_W-1:0]   err_count_o
);

  logic [autotest_pkg::BYTE_W-1:0] byte_idx;
  logic load_byte;
  logic buf_we;
  logic capture_out;
  logic timer_clr;
  logic timer_run;
  logic send_byte;
  logic sig_ok;
  logic result_bad;
  logic timed_out;
  logic [7:0] buf_byte;
  logic [autotest_pkg::OUT_W-1:0] result;
  logic [autotest_pkg::TIME_W-1:0] exec_time;

  autotest_fsm u_fsm (
    .clk(clk), .rst(rst), .start_i(start_i), .spi_busy_i(spi_busy_i),
    .sig_ok_i(sig_ok), .result_bad_i(result_bad),
    .uut_end_i(uut_end_i), .uut_err_i(uut_err_i), .timed_out_i(timed_out),
    .spi_rst_o(spi_rst_o), .spi_r_block_o(spi_r_block_o), .spi_r_byte_o(spi_r_byte_o),
    .spi_w_block_o(spi_w_block_o), .spi_w_byte_o(spi_w_byte_o),
    .spi_block_addr_o(spi_block_addr_o), .uut_rst_o(uut_rst_o),
    .byte_idx_o(byte_idx), .load_byte_o(load_byte), .buf_we_o(buf_we),
    .capture_out_o(capture_out), .timer_clr_o(timer_clr), .timer_run_o(timer_run),
    .send_byte_o(send_byte), .err_count_o(err_count_o)
  );

  // copy of the block for write-back
  block_buffer u_buffer (
    .clk(clk), .addr_i(byte_idx), .we_i(buf_we),
    .din_i(spi_data_out_i), .dout_o(buf_byte)
  );

  vector_capture u_capture (
    .clk(clk), .byte_idx_i(byte_idx), .load_byte_i(load_byte), .din_i(spi_data_out_i),
    .capture_out_i(capture_out), .uut_dout_i(uut_dout_i),
    .uut_din_o(uut_din_o), .sig_ok_o(sig_ok), .result_bad_o(result_bad),
    .result_o(result)
  );

  exec_timer u_timer (
    .clk(clk), .clr_i(timer_clr), .run_i(timer_run),
    .exec_time_o(exec_time), .timed_out_o(timed_out)
  );

  result_writer u_writer (
    .clk(clk), .send_i(send_byte), .byte_idx_i(byte_idx), .buf_byte_i(buf_byte),
    .result_i(result), .exec_time_i(exec_time), .spi_data_in_o(spi_data_in_o)
  );

endmodule

`default_nettype wire

//--- src/block_buffer.sv
// block buffer: 512x8 synchronous RAM holding the SD block in flight
`timescale 1ns/1ps
`default_nettype none

module block_buffer (
  input  logic                             clk,
  input  logic [autotest_pkg::BYTE_W-1:0]  addr_i,
  input  logic                             we_i,
  input  logic [7:0]                       din_i,
  output logic [7:0]                       dout_o
);

  logic [7:0] mem [autotest_pkg::BLOCK_BYTES];
  logic [$clog2(autotest_pkg::BLOCK_BYTES)-1:0] word;

  // index 512 past the last byte wraps, its data is never used
  assign word = addr_i[$clog2(autotest_pkg::BLOCK_BYTES)-1:0];

  always_ff @(posedge clk)
  begin
    if (we_i)
      mem[word] <= din_i;
    dout_o <= mem[word];
  end

endmodule

`default_nettype wire

//--- src/exec_timer.sv
// execution timer: 64-bit cycle count of the UUT run with timeout flag
`timescale 1ns/1ps
`default_nettype none

module exec_timer (
  input  logic                             clk,
  input  logic                             clr_i,
  input  logic                             run_i,
  output logic [autotest_pkg::TIME_W-1:0]  exec_time_o,
  output logic                             timed_out_o
);

  logic [autotest_pkg::TIME_W-1:0] count_q;

  always_ff @(posedge clk)
  begin
    if (clr_i)
      count_q <= '0;
    else if (run_i)
      count_q <= count_q + 1'b1;
  end

  assign exec_time_o = count_q;
  // fires so the edge leaving RUN takes the count just past the limit
  assign timed_out_o = count_q >= autotest_pkg::TIMEOUT_CYCLES;

endmodule

`default_nettype wire

//--- src/result_writer.sv
// write-back byte select: UUT result, execution time or the buffered block byte
`timescale 1ns/1ps
`default_nettype none

module result_writer (
  input  logic                             clk,
  input  logic                             send_i,
  input  logic [autotest_pkg::BYTE_W-1:0]  byte_idx_i,
  input  logic [7:0]                       buf_byte_i,
  input  logic [autotest_pkg::OUT_W-1:0]   result_i,
  input  logic [autotest_pkg::TIME_W-1:0]  exec_time_i,
  output logic [7:0]                       spi_data_in_o
);

  logic [7:0] pick;
  int idx;

  assign idx = int'(byte_idx_i);

  always_comb
  begin
    pick = buf_byte_i;
    for (int k = 0; k < autotest_pkg::OUT_BYTES; k++)
      if (idx == autotest_pkg::RES_BASE + k)
        pick = result_i[8*k +: 8];
    // time field sits right after the result field
    for (int k = 0; k < autotest_pkg::TIME_BYTES; k++)
      if (idx == autotest_pkg::RES_BASE + autotest_pkg::OUT_BYTES + k)
        pick = exec_time_i[8*k +: 8];
  end

  always_ff @(posedge clk)
  begin
    if (send_i)
      spi_data_in_o <= pick;
  end

endmodule

`default_nettype wire

//--- src/vector_capture.sv
// vector registers: signature, UUT input, expected and actual result, with checks
`timescale 1ns/1ps
`default_nettype none

module vector_capture (
  input  logic                             clk,
  input  logic [autotest_pkg::BYTE_W-1:0]  byte_idx_i,
  input  logic                             load_byte_i,
  input  logic [7:0]                       din_i,
  input  logic                             capture_out_i,
  input  logic [autotest_pkg::OUT_W-1:0]   uut_dout_i,
  output logic [autotest_pkg::IN_W-1:0]    uut_din_o,
  output logic                             sig_ok_o,
  output logic                             result_bad_o,
  output logic [autotest_pkg::OUT_W-1:0]   result_o
);

  logic [31:0] sig_q;
  logic [autotest_pkg::IN_W-1:0] din_q;
  logic [autotest_pkg::OUT_W-1:0] exp_q;
  logic [autotest_pkg::OUT_W-1:0] res_q;
  int idx;

  assign idx = int'(byte_idx_i);

  always_ff @(posedge clk)
  begin
    if (load_byte_i)
    begin
      // signature fills the bytes ahead of the input field
      for (int k = 0; k < autotest_pkg::IN_BASE; k++)
        if (idx == k)
          sig_q[8*(autotest_pkg::IN_BASE-1-k) +: 8] <= din_i;
      for (int k = 0; k < autotest_pkg::IN_BYTES; k++)
        if (idx == autotest_pkg::IN_BASE + k)
          din_q[8*k +: 8] <= din_i;
      for (int k = 0; k < autotest_pkg::OUT_BYTES; k++)
        if (idx == autotest_pkg::EXP_BASE + k)
          exp_q[8*k +: 8] <= din_i;
    end
    if (capture_out_i)
      res_q <= uut_dout_i;
  end

  assign uut_din_o = din_q;
  assign result_o = res_q;
  assign sig_ok_o = sig_q == autotest_pkg::SIGNATURE;
  assign result_bad_o = exp_q != res_q;

endmodule

`default_nettype wire

//--- verif/autotest_tb.sv
// testbench for the SD test sequencer: UUT model, reference model and write-back checks
`timescale 1ns/1ps
`default_nettype none

module autotest_tb;

  localparam int SEED = 32'h1414268f;
  localparam int BLOCKS = 6;
  localparam int VALID = 5;
  localparam int HANG_BLOCK = 2;
  localparam int TAIL_CYCLES = 1000;
  localparam int TO = int'(autotest_pkg::TIMEOUT_CYCLES);
  localparam int WATCHDOG_CYCLES = 8 + BLOCKS * (1100 * 6 + TO) + TAIL_CYCLES;
  localparam logic [31:0] ANSWER_OFFSET = 32'h1357_9bdf;
  localparam int TIME_BASE = autotest_pkg::RES_BASE + autotest_pkg::OUT_BYTES;
  localparam int MODE_OK = 0;
  localparam int MODE_BAD = 1;
  localparam int MODE_ERR = 2;
  localparam int MODE_HANG = 3;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic start;
  logic spi_busy;
  logic [7:0] spi_data_out;
  logic [31:0] spi_block_addr;
  logic spi_r_block;
  logic spi_r_byte;
  logic spi_rst;
  logic spi_w_block;
  logic spi_w_byte;
  logic [7:0] spi_data_in;
  logic uut_rst;
  logic [31:0] uut_din;
  logic uut_end;
  logic uut_err;
  logic [31:0] uut_dout;
  logic [15:0] err_count;

  int seed;
  int mode [VALID];
  logic [31:0] act_dout [VALID];
  int run_cycles [VALID];
  logic err_raised [VALID];
  int run_n;
  int end_at;
  logic in_run;
  logic [31:0] answer;
  logic [31:0] exp_word;
  logic [63:0] run_time;
  logic [7:0] want;
  int pick;
  int ref_errors;

  autotest_top DUT (
    .clk(clk), .rst(rst), .start_i(start),
    .spi_busy_i(spi_busy), .spi_data_out_i(spi_data_out),
    .spi_block_addr_o(spi_block_addr), .spi_r_block_o(spi_r_block),
    .spi_r_byte_o(spi_r_byte), .spi_rst_o(spi_rst), .spi_w_block_o(spi_w_block),
    .spi_w_byte_o(spi_w_byte), .spi_data_in_o(spi_data_in),
    .uut_rst_o(uut_rst), .uut_din_o(uut_din),
    .uut_end_i(uut_end), .uut_err_i(uut_err), .uut_dout_i(uut_dout),
    .err_count_o(err_count)
  );

  sd_card_model #(.SEED(SEED), .BLOCKS(BLOCKS)) card (
    .clk(clk), .rst_i(rst), .spi_rst_i(spi_rst),
    .r_block_i(spi_r_block), .r_byte_i(spi_r_byte),
    .w_block_i(spi_w_block), .w_byte_i(spi_w_byte),
    .block_addr_i(spi_block_addr), .data_in_i(spi_data_in),
    .busy_o(spi_busy), .data_out_o(spi_data_out)
  );

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'({$random(seed)} % (hi - lo + 1));
  endfunction

  // little-endian 32-bit field of the card image
  function automatic logic [31:0] field32(input int b, input int base);
    logic [31:0] v;
    for (int k = 0; k < 4; k++)
      v[8*k +: 8] = card.img[b][base + k];
    return v;
  endfunction

  task automatic expect_equal(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  initial
  begin
    forever #50 clk = ~clk;
  end

  // UUT model, answers input plus a constant after a random delay
  always @(negedge clk)
  begin
    if (rst || uut_rst)
    begin
      if (in_run)
        run_n = run_n + 1;
      in_run = 1'b0;
      uut_end = 1'b0;
      uut_err = 1'b0;
    end
    else
    begin
      if (!in_run)
      begin
        expect_equal(64'(run_n < VALID), 64'd1, "UUT run count within valid blocks");
        expect_equal(64'(uut_din), 64'(field32(run_n, autotest_pkg::IN_BASE)),
                     "UUT input word");
        in_run = 1'b1;
        run_cycles[run_n] = 0;
        end_at = rand_range(5, 50);
        uut_dout = '0;
        act_dout[run_n] = '0;
        err_raised[run_n] = 1'b0;
      end
      run_cycles[run_n] = run_cycles[run_n] + 1;
      if (run_cycles[run_n] == end_at && mode[run_n] != MODE_HANG)
      begin
        answer = field32(run_n, autotest_pkg::IN_BASE) + ANSWER_OFFSET;
        if (mode[run_n] == MODE_BAD)
          answer = answer ^ (32'd1 << rand_range(0, 31));
        uut_dout = answer;
        act_dout[run_n] = answer;
        uut_end = mode[run_n] != MODE_ERR;
        uut_err = mode[run_n] == MODE_ERR;
        err_raised[run_n] = mode[run_n] == MODE_ERR;
      end
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the sequencer did not get through its blocks in the allowed time");
    $display("Test failed");
    $fatal(1);
  end

  initial
  begin
    seed = SEED;
    start = 1'b0;
    uut_end = 1'b0;
    uut_err = 1'b0;
    uut_dout = '0;
    run_n = 0;
    in_run = 1'b0;
    repeat (8) @(negedge clk);
    // pick a behaviour per block and fill in its expected field
    for (int b = 0; b < VALID; b++)
    begin
      pick = rand_range(0, 5);
      if (b == HANG_BLOCK)
        mode[b] = MODE_HANG;
      else if (pick == 0)
        mode[b] = MODE_BAD;
      else if (pick == 1)
        mode[b] = MODE_ERR;
      else
        mode[b] = MODE_OK;
      exp_word = field32(b, autotest_pkg::IN_BASE) + ANSWER_OFFSET;
      if (rand_range(0, 3) == 0)
        exp_word = 32'($random(seed));
      for (int k = 0; k < 4; k++)
        card.img[b][autotest_pkg::EXP_BASE + k] = exp_word[8*k +: 8];
    end
    rst = 1'b0;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;

    while (!(card.rd_n == BLOCKS && card.rd_idx == autotest_pkg::BLOCK_BYTES))
      @(negedge clk);
    // long quiet stretch, no read or write may follow the bad block
    repeat (TAIL_CYCLES) @(negedge clk);

    expect_equal(64'(card.rd_n), 64'(BLOCKS), "number of block reads");
    expect_equal(64'(card.wr_n), 64'(VALID), "number of block writes");
    expect_equal(64'(run_n), 64'(VALID), "number of UUT runs");
    ref_errors = 0;
    for (int b = 0; b < BLOCKS; b++)
      expect_equal(64'(card.rd_addr[b]), 64'(autotest_pkg::START_BLOCK + b),
                   $sformatf("read address of block %0d", b));
    for (int b = 0; b < VALID; b++)
    begin
      expect_equal(64'(card.wr_addr[b]), 64'(card.rd_addr[b]),
                   $sformatf("write address of block %0d", b));
      expect_equal(64'(card.wr_len[b]), 64'(autotest_pkg::BLOCK_BYTES),
                   $sformatf("bytes written for block %0d", b));
      if (mode[b] == MODE_HANG)
        expect_equal(64'(run_cycles[b]), 64'(TO + 1), "run length of the timed-out block");
      run_time = 64'(run_cycles[b]);
      for (int i = 0; i < autotest_pkg::BLOCK_BYTES; i++)
      begin
        if (i >= autotest_pkg::RES_BASE && i < TIME_BASE)
          want = act_dout[b][8*(i - autotest_pkg::RES_BASE) +: 8];
        else if (i >= TIME_BASE && i < TIME_BASE + autotest_pkg::TIME_BYTES)
          want = run_time[8*(i - TIME_BASE) +: 8];
        else
          want = card.img[b][i];
        expect_equal(64'(card.wr_img[b][i]), 64'(want),
                     $sformatf("block %0d written byte %0d", b, i));
      end
      if (field32(b, autotest_pkg::EXP_BASE) != act_dout[b] || err_raised[b])
        ref_errors++;
    end
    expect_equal(64'(err_count), 64'(ref_errors), "error count");
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/sd_card_model.sv
// SD card model: SPI host busy handshakes over a random block image, captures written bytes
`timescale 1ns/1ps
`default_nettype none

module sd_card_model #(
  parameter int SEED = 32'h1414268f,
  parameter int BLOCKS = 6
) (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        spi_rst_i,
  input  logic        r_block_i,
  input  logic        r_byte_i,
  input  logic        w_block_i,
  input  logic        w_byte_i,
  input  logic [31:0] block_addr_i,
  input  logic [7:0]  data_in_i,
  output logic        busy_o,
  output logic [7:0]  data_out_o
);

  localparam int NBYTES = autotest_pkg::BLOCK_BYTES;

  logic [7:0] img [BLOCKS][NBYTES];
  logic [7:0] wr_img [BLOCKS][NBYTES];
  logic [31:0] rd_addr [16];
  logic [31:0] wr_addr [16];
  int wr_len [BLOCKS];
  int rd_n;
  int wr_n;
  int rd_idx;
  int wr_idx;
  int blk;
  logic rd_open;
  logic wr_open;
  int seed;

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'({$random(seed)} % (hi - lo + 1));
  endfunction

  // -1 for an address outside the image
  function automatic int block_of(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - autotest_pkg::START_BLOCK;
    return (off < BLOCKS) ? int'(off) : -1;
  endfunction

  task automatic busy_pulse;
    int len;
    len = rand_range(1, 4);
    busy_o = 1'b1;
    repeat (len) @(negedge clk);
    busy_o = 1'b0;
  endtask

  initial
  begin
    seed = SEED;
    busy_o = 1'b0;
    data_out_o = 8'h00;
    rd_n = 0;
    wr_n = 0;
    rd_idx = 0;
    wr_idx = 0;
    rd_open = 1'b0;
    wr_open = 1'b0;
    for (int b = 0; b < BLOCKS; b++)
    begin
      wr_len[b] = 0;
      for (int i = 0; i < NBYTES; i++)
        img[b][i] = 8'($random(seed));
      for (int k = 0; k < 4; k++)
        img[b][k] = autotest_pkg::SIGNATURE[8*(3-k) +: 8];
    end
    // last block carries a damaged signature
    img[BLOCKS-1][3] = ~img[BLOCKS-1][3];
  end

  always
  begin
    @(negedge clk);
    if (!r_block_i)
      rd_open = 1'b0;
    if (!w_block_i)
      wr_open = 1'b0;
    if (rst_i)
      busy_o = 1'b0;
    else if (spi_rst_i)
      busy_pulse();
    else if (r_block_i && !rd_open)
    begin
      rd_open = 1'b1;
      if (rd_n < 16)
        rd_addr[rd_n] = block_addr_i;
      rd_n++;
      rd_idx = 0;
      busy_pulse();
    end
    else if (r_byte_i)
    begin
      blk = block_of(block_addr_i);
      if (blk >= 0)
        data_out_o = img[blk][rd_idx % NBYTES];
      else
        data_out_o = 8'hff;
      rd_idx++;
      busy_pulse();
    end
    else if (w_block_i && !wr_open)
    begin
      wr_open = 1'b1;
      if (wr_n < 16)
        wr_addr[wr_n] = block_addr_i;
      wr_n++;
      wr_idx = 0;
      busy_pulse();
    end
    else if (w_byte_i)
    begin
      // data is taken on the cycle busy rises
      blk = block_of(block_addr_i);
      if (blk >= 0)
      begin
        if (wr_idx < NBYTES)
          wr_img[blk][wr_idx] = data_in_i;
        wr_len[blk] = wr_idx + 1;
      end
      wr_idx++;
      busy_pulse();
    end
  end

endmodule

`default_nettype wire
